// File: verilog/rvfi_pkg.sv
// retirement record format shared by the lockstep checker blocks
// holds field widths, the mismatch field indices and the intr decode
package rvfi_pkg;

  localparam int XLEN      = 32;
  localparam int INTR_W    = 14;
  localparam int MODE_W    = 2;
  localparam int DBG_W     = 3;
  localparam int NMIP_W    = 2;
  localparam int RD_ADDR_W = 5;
  localparam int MASK_W    = 4;

  // packed core retirement, same order as the concatenation in the top
  localparam int RETIRE_W = XLEN + XLEN + XLEN + 1 + 1 + DBG_W + 1 + NMIP_W + INTR_W +
                            MODE_W + RD_ADDR_W + XLEN + MASK_W + MASK_W + XLEN + XLEN + XLEN;

  // one bit per compared field in the mismatch vector
  localparam int NUM_FIELDS = 18;

  localparam int F_PC_RDATA   = 0;
  localparam int F_PC_WDATA   = 1;
  localparam int F_INSN       = 2;
  localparam int F_TRAP       = 3;
  localparam int F_HALT       = 4;
  localparam int F_DBG        = 5;
  localparam int F_DBG_MODE   = 6;
  localparam int F_NMIP       = 7;
  localparam int F_INTR_KIND  = 8;
  localparam int F_INTR_CAUSE = 9;
  localparam int F_MODE       = 10;
  localparam int F_RD1_ADDR   = 11;
  localparam int F_RD1_WDATA  = 12;
  localparam int F_MEM_RMASK  = 13;
  localparam int F_MEM_WMASK  = 14;
  localparam int F_MEM_ADDR   = 15;
  localparam int F_MEM_WDATA  = 16;
  localparam int F_MEM_RDATA  = 17;

  // intr word, either raw or split into cause and kind bits
  typedef union packed {
    logic [INTR_W-1:0] raw;
    struct packed {
      logic [10:0] cause;
      logic        debug;
      logic        exception;
      logic        interrupt;
    } dec;
  } rvfi_intr_u;

endpackage

// File: verilog/rvfi_cmp_regs_pkg.sv
// register map of the checker's wishbone slave
// byte offsets and status bit positions
package rvfi_cmp_regs_pkg;

  localparam int ADR_W = 5;

  localparam logic [ADR_W-1:0] REG_STATUS       = 5'h00;
  localparam logic [ADR_W-1:0] REG_CTRL         = 5'h04;
  localparam logic [ADR_W-1:0] REG_CHECK_CNT    = 5'h08;
  localparam logic [ADR_W-1:0] REG_MISMATCH_CNT = 5'h0C;
  localparam logic [ADR_W-1:0] REG_FIRST_FIELDS = 5'h10;
  localparam logic [ADR_W-1:0] REG_FIRST_PC     = 5'h14;

  // sticky flags in STATUS
  localparam int ST_MISMATCH = 0;
  localparam int ST_ORDER    = 1;
  localparam int ST_OVERFLOW = 2;

  // bit 0 of CTRL clears the log
  localparam int CTRL_CLEAR = 0;

endpackage

// File: verilog/rvfi_retire_fifo.sv
// show-ahead buffer for core retirements waiting on the reference model
// an empty buffer forwards the incoming word so a same-cycle pop skips storage
module rvfi_retire_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             rvfi_core,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] wdata_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] rdata_o,
  output logic             valid_o,
  output logic             overflow_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    rd_ptr;
  logic [AW-1:0]    wr_ptr;
  logic [AW:0]      level;
  logic             empty;
  logic             full;
  logic             do_write;
  logic             do_read;

  assign empty = (level == '0);
  assign full  = (level == (AW+1)'(DEPTH));

  assign rdata_o = empty ? wdata_i : mem[rd_ptr];
  assign valid_o = !empty || push_i;

  // a bypassed word is consumed right away, a full buffer only takes a word on pop
  assign do_write   = push_i && !(empty && pop_i) && (!full || pop_i);
  assign do_read    = pop_i && !empty;
  assign overflow_o = push_i && full && !pop_i;

  always_ff @(posedge rvfi_core) begin
    if (do_write) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (rst_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      level <= level + (AW+1)'(do_write) - (AW+1)'(do_read);
    end
  end

  level_bound_a: assert property (@(posedge rvfi_core) disable iff (rst_i)
    level <= (AW+1)'(DEPTH));

  pop_valid_a: assert property (@(posedge rvfi_core) disable iff (rst_i)
    pop_i |-> valid_o);

endmodule

// File: verilog/rvfi_field_compare.sv
// field-by-field check of a reference retirement against the oldest core one
// data-dependent fields are masked as the retirement itself dictates
module rvfi_field_compare (
  input  logic                          rvfi_core,
  input  logic                          exp_valid_i,
  input  logic [rvfi_pkg::RETIRE_W-1:0] exp_data_i,
  input  logic                          rm_valid_i,
  input  logic [rvfi_pkg::XLEN-1:0]     rm_pc_rdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]     rm_pc_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]     rm_insn_i,
  input  logic                          rm_trap_i,
  input  logic                          rm_halt_i,
  input  logic [rvfi_pkg::DBG_W-1:0]    rm_dbg_i,
  input  logic                          rm_dbg_mode_i,
  input  logic [rvfi_pkg::NMIP_W-1:0]   rm_nmip_i,
  input  logic [rvfi_pkg::INTR_W-1:0]   rm_intr_i,
  input  logic [rvfi_pkg::MODE_W-1:0]   rm_mode_i,
  input  logic [rvfi_pkg::RD_ADDR_W-1:0] rm_rd1_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]     rm_rd1_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]     rm_mem_addr_i,
  input  logic [rvfi_pkg::MASK_W-1:0]   rm_mem_rmask_i,
  input  logic [rvfi_pkg::MASK_W-1:0]   rm_mem_wmask_i,
  input  logic [rvfi_pkg::XLEN-1:0]     rm_mem_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]     rm_mem_rdata_i,
  output logic                          check_o,
  output logic [rvfi_pkg::NUM_FIELDS-1:0] mismatch_o,
  output logic                          order_err_o
);
  import rvfi_pkg::*;

  logic [XLEN-1:0]      exp_pc_rdata, exp_pc_wdata, exp_insn, exp_rd1_wdata;
  logic [XLEN-1:0]      exp_mem_addr, exp_mem_wdata, exp_mem_rdata;
  logic                 exp_trap, exp_halt, exp_dbg_mode;
  logic [DBG_W-1:0]     exp_dbg;
  logic [NMIP_W-1:0]    exp_nmip;
  logic [INTR_W-1:0]    exp_intr_raw;
  logic [MODE_W-1:0]    exp_mode;
  logic [RD_ADDR_W-1:0] exp_rd1_addr;
  logic [MASK_W-1:0]    exp_mem_rmask, exp_mem_wmask;
  rvfi_intr_u           exp_intr;
  rvfi_intr_u           rm_intr;
  logic [NUM_FIELDS-1:0] diff;

  assign {exp_pc_rdata, exp_pc_wdata, exp_insn, exp_trap, exp_halt, exp_dbg, exp_dbg_mode,
          exp_nmip, exp_intr_raw, exp_mode, exp_rd1_addr, exp_rd1_wdata, exp_mem_rmask,
          exp_mem_wmask, exp_mem_addr, exp_mem_wdata, exp_mem_rdata} = exp_data_i;

  assign exp_intr = exp_intr_raw;
  assign rm_intr  = rm_intr_i;

  always_comb begin
    diff[F_PC_RDATA]  = exp_pc_rdata != rm_pc_rdata_i;
    diff[F_PC_WDATA]  = exp_pc_wdata != rm_pc_wdata_i;
    diff[F_INSN]      = exp_insn != rm_insn_i;
    diff[F_TRAP]      = exp_trap != rm_trap_i;
    diff[F_HALT]      = exp_halt != rm_halt_i;
    diff[F_DBG]       = exp_dbg != rm_dbg_i;
    diff[F_DBG_MODE]  = exp_dbg_mode != rm_dbg_mode_i;
    diff[F_NMIP]      = exp_nmip != rm_nmip_i;
    diff[F_INTR_KIND] = {exp_intr.dec.debug, exp_intr.dec.exception, exp_intr.dec.interrupt} !=
                        {rm_intr.dec.debug, rm_intr.dec.exception, rm_intr.dec.interrupt};
    // cause only means something when a trap was actually taken
    diff[F_INTR_CAUSE] = (rm_intr.dec.interrupt || rm_intr.dec.exception) &&
                         (exp_intr.dec.cause != rm_intr.dec.cause);
    diff[F_MODE]      = exp_mode != rm_mode_i;
    diff[F_RD1_ADDR]  = exp_rd1_addr != rm_rd1_addr_i;
    // writes to x0 carry no data
    diff[F_RD1_WDATA] = (rm_rd1_addr_i != '0) && (exp_rd1_wdata != rm_rd1_wdata_i);
    diff[F_MEM_RMASK] = exp_mem_rmask != rm_mem_rmask_i;
    diff[F_MEM_WMASK] = exp_mem_wmask != rm_mem_wmask_i;
    // memory fields follow the core's byte masks
    diff[F_MEM_ADDR]  = ((exp_mem_rmask | exp_mem_wmask) != '0) && (exp_mem_addr != rm_mem_addr_i);
    diff[F_MEM_WDATA] = (exp_mem_wmask != '0) && (exp_mem_wdata != rm_mem_wdata_i);
    diff[F_MEM_RDATA] = (exp_mem_rmask != '0) && (exp_mem_rdata != rm_mem_rdata_i);
  end

  assign check_o     = rm_valid_i && exp_valid_i;
  assign order_err_o = rm_valid_i && !exp_valid_i;
  assign mismatch_o  = check_o ? diff : '0;

  // a checked retirement yields a fully defined field vector
  check_defined_a: assert property (@(posedge rvfi_core)
    check_o |-> !$isunknown(mismatch_o));

endmodule

// File: verilog/rvfi_mismatch_log.sv
// result log of the checker
// counts checks and mismatches, keeps the first mismatch and the sticky error flags
module rvfi_mismatch_log (
  input  logic                            rvfi_core,
  input  logic                            rst_i,
  input  logic                            check_i,
  input  logic [rvfi_pkg::NUM_FIELDS-1:0] mismatch_i,
  input  logic [rvfi_pkg::XLEN-1:0]       rm_pc_i,
  input  logic                            order_err_i,
  input  logic                            overflow_i,
  input  logic                            clear_i,
  output logic [31:0]                     check_cnt_o,
  output logic [31:0]                     mismatch_cnt_o,
  output logic [rvfi_pkg::NUM_FIELDS-1:0] first_fields_o,
  output logic [rvfi_pkg::XLEN-1:0]       first_pc_o,
  output logic [2:0]                      status_o,
  output logic                            err_irq_o
);
  import rvfi_cmp_regs_pkg::*;

  logic any_mismatch;

  assign any_mismatch = check_i && (mismatch_i != '0);

  always_ff @(posedge rvfi_core) begin
    if (rst_i || clear_i) begin
      check_cnt_o    <= '0;
      mismatch_cnt_o <= '0;
      first_fields_o <= '0;
      first_pc_o     <= '0;
      status_o       <= '0;
      err_irq_o      <= 1'b0;
    end else begin
      if (check_i) begin
        check_cnt_o <= check_cnt_o + 32'd1;
      end
      // one count per failing check, however many fields differ
      if (any_mismatch) begin
        mismatch_cnt_o <= mismatch_cnt_o + 32'd1;
      end
      if (any_mismatch && !status_o[ST_MISMATCH]) begin
        first_fields_o <= mismatch_i;
        first_pc_o     <= rm_pc_i;
      end
      if (any_mismatch) begin
        status_o[ST_MISMATCH] <= 1'b1;
      end
      if (order_err_i) begin
        status_o[ST_ORDER] <= 1'b1;
      end
      if (overflow_i) begin
        status_o[ST_OVERFLOW] <= 1'b1;
      end
      // follows the flags one edge behind
      err_irq_o <= (status_o != '0);
    end
  end

  first_capture_held_a: assert property (@(posedge rvfi_core) disable iff (rst_i)
    status_o[ST_MISMATCH] |-> (first_fields_o != '0));

endmodule

// File: verilog/rvfi_cmp_wb_regs.sv
// wishbone classic slave for the checker's result registers
// two-cycle accesses with a registered ack, a CTRL write can clear the log
module rvfi_cmp_wb_regs (
  input  logic                                 rvfi_core,
  input  logic                                 rst_i,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [rvfi_cmp_regs_pkg::ADR_W-1:0]  wb_adr_i,
  input  logic [31:0]                          wb_dat_i,
  input  logic [3:0]                           wb_sel_i,
  output logic [31:0]                          wb_dat_o,
  output logic                                 wb_ack_o,
  input  logic [31:0]                          check_cnt_i,
  input  logic [31:0]                          mismatch_cnt_i,
  input  logic [rvfi_pkg::NUM_FIELDS-1:0]      first_fields_i,
  input  logic [rvfi_pkg::XLEN-1:0]            first_pc_i,
  input  logic [2:0]                           status_i,
  output logic                                 clear_o
);
  import rvfi_cmp_regs_pkg::*;

  logic        start;
  logic [31:0] rd_word;

  // a new request is served only if the previous cycle was not an ack
  assign start = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_comb begin
    case (wb_adr_i)
      REG_STATUS:       rd_word = 32'(status_i);
      REG_CTRL:         rd_word = '0;
      REG_CHECK_CNT:    rd_word = check_cnt_i;
      REG_MISMATCH_CNT: rd_word = mismatch_cnt_i;
      REG_FIRST_FIELDS: rd_word = 32'(first_fields_i);
      REG_FIRST_PC:     rd_word = 32'(first_pc_i);
      default:          rd_word = '0;
    endcase
  end

  always_ff @(posedge rvfi_core) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
      clear_o  <= 1'b0;
    end else begin
      wb_ack_o <= start;
      clear_o  <= start && wb_we_i && wb_sel_i[0] && (wb_adr_i == REG_CTRL) &&
                  wb_dat_i[CTRL_CLEAR];
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (start) begin
      wb_dat_o <= rd_word;
    end
  end

  ack_in_cycle_a: assert property (@(posedge rvfi_core) disable iff (rst_i)
    wb_ack_o |-> wb_cyc_i);

  ack_single_a: assert property (@(posedge rvfi_core) disable iff (rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// File: verilog/rvfi_checker_top.sv
// lockstep retirement checker between a core and a reference model
// buffers core retirements, compares them in order and reports over wishbone
module rvfi_checker_top (
  input  logic                                rvfi_core,
  input  logic                                rst_i,
  input  logic                                core_valid_i,
  input  logic [rvfi_pkg::XLEN-1:0]           core_pc_rdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           core_pc_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           core_insn_i,
  input  logic                                core_trap_i,
  input  logic                                core_halt_i,
  input  logic [rvfi_pkg::DBG_W-1:0]          core_dbg_i,
  input  logic                                core_dbg_mode_i,
  input  logic [rvfi_pkg::NMIP_W-1:0]         core_nmip_i,
  input  logic [rvfi_pkg::INTR_W-1:0]         core_intr_i,
  input  logic [rvfi_pkg::MODE_W-1:0]         core_mode_i,
  input  logic [rvfi_pkg::RD_ADDR_W-1:0]      core_rd1_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]           core_rd1_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           core_mem_addr_i,
  input  logic [rvfi_pkg::MASK_W-1:0]         core_mem_rmask_i,
  input  logic [rvfi_pkg::MASK_W-1:0]         core_mem_wmask_i,
  input  logic [rvfi_pkg::XLEN-1:0]           core_mem_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           core_mem_rdata_i,
  input  logic                                rm_valid_i,
  input  logic [rvfi_pkg::XLEN-1:0]           rm_pc_rdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           rm_pc_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           rm_insn_i,
  input  logic                                rm_trap_i,
  input  logic                                rm_halt_i,
  input  logic [rvfi_pkg::DBG_W-1:0]          rm_dbg_i,
  input  logic                                rm_dbg_mode_i,
  input  logic [rvfi_pkg::NMIP_W-1:0]         rm_nmip_i,
  input  logic [rvfi_pkg::INTR_W-1:0]         rm_intr_i,
  input  logic [rvfi_pkg::MODE_W-1:0]         rm_mode_i,
  input  logic [rvfi_pkg::RD_ADDR_W-1:0]      rm_rd1_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]           rm_rd1_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           rm_mem_addr_i,
  input  logic [rvfi_pkg::MASK_W-1:0]         rm_mem_rmask_i,
  input  logic [rvfi_pkg::MASK_W-1:0]         rm_mem_wmask_i,
  input  logic [rvfi_pkg::XLEN-1:0]           rm_mem_wdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]           rm_mem_rdata_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [rvfi_cmp_regs_pkg::ADR_W-1:0] wb_adr_i,
  input  logic [31:0]                         wb_dat_i,
  input  logic [3:0]                          wb_sel_i,
  output logic [31:0]                         wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                err_irq_o
);
  import rvfi_pkg::*;

  logic [RETIRE_W-1:0]   exp_data;
  logic                  exp_valid, check, order_err, overflow, clear;
  logic [NUM_FIELDS-1:0] mismatch, first_fields;
  logic [31:0]           check_cnt, mismatch_cnt;
  logic [XLEN-1:0]       first_pc;
  logic [2:0]            status;

  // field order here must match the unpack in the compare block
  rvfi_retire_fifo #(.WIDTH(RETIRE_W), .DEPTH(4)) u_fifo (
    .rvfi_core, .rst_i,
    .push_i     (core_valid_i),
    .wdata_i    ({core_pc_rdata_i, core_pc_wdata_i, core_insn_i, core_trap_i, core_halt_i,
                  core_dbg_i, core_dbg_mode_i, core_nmip_i, core_intr_i, core_mode_i,
                  core_rd1_addr_i, core_rd1_wdata_i, core_mem_rmask_i, core_mem_wmask_i,
                  core_mem_addr_i, core_mem_wdata_i, core_mem_rdata_i}),
    .pop_i      (check),
    .rdata_o    (exp_data),
    .valid_o    (exp_valid),
    .overflow_o (overflow)
  );

  rvfi_field_compare u_compare (
    .rvfi_core, .exp_valid_i(exp_valid), .exp_data_i(exp_data),
    .rm_valid_i, .rm_pc_rdata_i, .rm_pc_wdata_i, .rm_insn_i, .rm_trap_i, .rm_halt_i,
    .rm_dbg_i, .rm_dbg_mode_i, .rm_nmip_i, .rm_intr_i, .rm_mode_i, .rm_rd1_addr_i,
    .rm_rd1_wdata_i, .rm_mem_addr_i, .rm_mem_rmask_i, .rm_mem_wmask_i, .rm_mem_wdata_i,
    .rm_mem_rdata_i,
    .check_o(check), .mismatch_o(mismatch), .order_err_o(order_err)
  );

  rvfi_mismatch_log u_log (
    .rvfi_core, .rst_i, .check_i(check), .mismatch_i(mismatch), .rm_pc_i(rm_pc_rdata_i),
    .order_err_i(order_err), .overflow_i(overflow), .clear_i(clear),
    .check_cnt_o(check_cnt), .mismatch_cnt_o(mismatch_cnt), .first_fields_o(first_fields),
    .first_pc_o(first_pc), .status_o(status), .err_irq_o
  );

  rvfi_cmp_wb_regs u_regs (
    .rvfi_core, .rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o,
    .check_cnt_i(check_cnt), .mismatch_cnt_i(mismatch_cnt), .first_fields_i(first_fields),
    .first_pc_i(first_pc), .status_i(status), .clear_o(clear)
  );

endmodule

// File: tests/tb_rvfi_checker.sv
// directed testbench for the lockstep retirement checker
// drives the core and reference streams and reads the results over wishbone
module tb_rvfi_checker;
  timeunit 1ns;
  timeprecision 100ps;
  import rvfi_pkg::*;
  import rvfi_cmp_regs_pkg::*;

  localparam int ACK_TIMEOUT = 20;

  // one retirement as the testbench sees it, not the DUT's packing
  typedef struct packed {
    logic [XLEN-1:0]      pc_rdata;
    logic [XLEN-1:0]      pc_wdata;
    logic [XLEN-1:0]      insn;
    logic                 trap;
    logic                 halt;
    logic [DBG_W-1:0]     dbg;
    logic                 dbg_mode;
    logic [NMIP_W-1:0]    nmip;
    logic [INTR_W-1:0]    intr;
    logic [MODE_W-1:0]    mode;
    logic [RD_ADDR_W-1:0] rd1_addr;
    logic [XLEN-1:0]      rd1_wdata;
    logic [XLEN-1:0]      mem_addr;
    logic [MASK_W-1:0]    mem_rmask;
    logic [MASK_W-1:0]    mem_wmask;
    logic [XLEN-1:0]      mem_wdata;
    logic [XLEN-1:0]      mem_rdata;
  } retire_t;

  logic                 rvfi_core;
  logic                 rst_i;
  logic                 core_valid_i, rm_valid_i;
  logic [XLEN-1:0]      core_pc_rdata_i, core_pc_wdata_i, core_insn_i, core_rd1_wdata_i;
  logic [XLEN-1:0]      core_mem_addr_i, core_mem_wdata_i, core_mem_rdata_i;
  logic                 core_trap_i, core_halt_i, core_dbg_mode_i;
  logic [DBG_W-1:0]     core_dbg_i, rm_dbg_i;
  logic [NMIP_W-1:0]    core_nmip_i, rm_nmip_i;
  logic [INTR_W-1:0]    core_intr_i, rm_intr_i;
  logic [MODE_W-1:0]    core_mode_i, rm_mode_i;
  logic [RD_ADDR_W-1:0] core_rd1_addr_i, rm_rd1_addr_i;
  logic [MASK_W-1:0]    core_mem_rmask_i, core_mem_wmask_i, rm_mem_rmask_i, rm_mem_wmask_i;
  logic [XLEN-1:0]      rm_pc_rdata_i, rm_pc_wdata_i, rm_insn_i, rm_rd1_wdata_i;
  logic [XLEN-1:0]      rm_mem_addr_i, rm_mem_wdata_i, rm_mem_rdata_i;
  logic                 rm_trap_i, rm_halt_i, rm_dbg_mode_i;
  logic                 wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o, err_irq_o;
  logic [ADR_W-1:0]     wb_adr_i;
  logic [31:0]          wb_dat_i, wb_dat_o;
  logic [3:0]           wb_sel_i;

  rvfi_checker_top u_dut (.*);

  initial begin
    rvfi_core = 1'b0;
    forever #20 rvfi_core = ~rvfi_core;
  end

  task automatic step();
    @(posedge rvfi_core);
    #2;
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else
      fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want));
  endtask

  // cyc and stb are held until the edge after the ack edge
  task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    wb_sel_i = 4'hF;
    n = 0;
    do begin
      step();
      n++;
    end while (!wb_ack_o && n < ACK_TIMEOUT);
    if (!wb_ack_o) begin
      fail_run($sformatf("no wishbone ack within %0d cycles at offset 0x%02h", n, adr));
    end
    rdat = wb_dat_o;
    step();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'd0, data);
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] ignored;
    wb_access(1'b1, adr, data, ignored);
  endtask

  task automatic read_expect(input logic [ADR_W-1:0] adr, input string name,
                             input logic [31:0] want);
    logic [31:0] got;
    wb_read(adr, got);
    expect_eq({"wb_dat_o ", name}, got, want);
  endtask

  function automatic retire_t random_retire();
    logic [10*32-1:0] bits;
    for (int i = 0; i < 10; i++) begin
      bits[i*32 +: 32] = $urandom;
    end
    return bits[$bits(retire_t)-1:0];
  endfunction

  // one retirement cycle, either stream may stay idle
  task automatic retire(input logic cv, input retire_t c, input logic rv, input retire_t r);
    core_valid_i = cv;
    rm_valid_i   = rv;
    {core_pc_rdata_i, core_pc_wdata_i, core_insn_i, core_trap_i, core_halt_i, core_dbg_i,
     core_dbg_mode_i, core_nmip_i, core_intr_i, core_mode_i, core_rd1_addr_i, core_rd1_wdata_i,
     core_mem_addr_i, core_mem_rmask_i, core_mem_wmask_i, core_mem_wdata_i, core_mem_rdata_i} = c;
    {rm_pc_rdata_i, rm_pc_wdata_i, rm_insn_i, rm_trap_i, rm_halt_i, rm_dbg_i,
     rm_dbg_mode_i, rm_nmip_i, rm_intr_i, rm_mode_i, rm_rd1_addr_i, rm_rd1_wdata_i,
     rm_mem_addr_i, rm_mem_rmask_i, rm_mem_wmask_i, rm_mem_wdata_i, rm_mem_rdata_i} = r;
    step();
    core_valid_i = 1'b0;
    rm_valid_i   = 1'b0;
  endtask

  // aligned streams go through the bypass
  task automatic aligned_match();
    retire_t c;
    repeat (10) begin
      c = random_retire();
      retire(1'b1, c, 1'b1, c);
      expect_eq("err_irq_o", 32'(err_irq_o), 32'd0);
    end
    read_expect(REG_CHECK_CNT, "CHECK_CNT", 32'd10);
    read_expect(REG_MISMATCH_CNT, "MISMATCH_CNT", 32'd0);
    read_expect(REG_STATUS, "STATUS", 32'd0);
  endtask

  // reference trails the core by three retirements
  task automatic skewed_match();
    retire_t recs [3];
    for (int i = 0; i < 3; i++) begin
      recs[i] = random_retire();
      retire(1'b1, recs[i], 1'b0, '0);
    end
    for (int i = 0; i < 3; i++) begin
      retire(1'b0, '0, 1'b1, recs[i]);
    end
    read_expect(REG_CHECK_CNT, "CHECK_CNT", 32'd13);
    read_expect(REG_MISMATCH_CNT, "MISMATCH_CNT", 32'd0);
  endtask

  // x0 write, no memory access and no trap, so the data fields are don't care
  task automatic masked_fields();
    retire_t c;
    retire_t r;
    c = random_retire();
    c.rd1_addr  = '0;
    c.mem_rmask = '0;
    c.mem_wmask = '0;
    c.intr      = {c.intr[INTR_W-1:3], 3'b000};
    r = c;
    r.rd1_wdata = ~c.rd1_wdata;
    r.mem_addr  = ~c.mem_addr;
    r.mem_wdata = ~c.mem_wdata;
    r.mem_rdata = ~c.mem_rdata;
    r.intr      = {~c.intr[INTR_W-1:3], 3'b000};
    retire(1'b1, c, 1'b1, r);
    read_expect(REG_CHECK_CNT, "CHECK_CNT", 32'd14);
    read_expect(REG_MISMATCH_CNT, "MISMATCH_CNT", 32'd0);
    read_expect(REG_STATUS, "STATUS", 32'd0);
  endtask

  // first mismatch is kept, the second only counts
  task automatic first_mismatch_capture();
    retire_t         c;
    retire_t         r;
    logic [XLEN-1:0] first_pc;
    c = random_retire();
    c.mem_wmask = 4'h3;
    first_pc = c.pc_rdata;
    r = c;
    r.insn      = ~c.insn;
    r.mem_wdata = ~c.mem_wdata;
    retire(1'b1, c, 1'b1, r);
    c = random_retire();
    r = c;
    r.trap = ~c.trap;
    retire(1'b1, c, 1'b1, r);
    read_expect(REG_CHECK_CNT, "CHECK_CNT", 32'd16);
    read_expect(REG_MISMATCH_CNT, "MISMATCH_CNT", 32'd2);
    read_expect(REG_FIRST_FIELDS, "FIRST_FIELDS", (32'd1 << F_INSN) | (32'd1 << F_MEM_WDATA));
    read_expect(REG_FIRST_PC, "FIRST_PC", first_pc);
    read_expect(REG_STATUS, "STATUS", 32'd1 << ST_MISMATCH);
    expect_eq("err_irq_o", 32'(err_irq_o), 32'd1);
  endtask

  // reference with nothing buffered, then one core retirement too many
  task automatic stream_errors();
    retire_t recs [5];
    retire(1'b0, '0, 1'b1, random_retire());
    read_expect(REG_STATUS, "STATUS", (32'd1 << ST_MISMATCH) | (32'd1 << ST_ORDER));
    for (int i = 0; i < 5; i++) begin
      recs[i] = random_retire();
      retire(1'b1, recs[i], 1'b0, '0);
    end
    read_expect(REG_STATUS, "STATUS",
                (32'd1 << ST_MISMATCH) | (32'd1 << ST_ORDER) | (32'd1 << ST_OVERFLOW));
    // the fifth entry was dropped, the first four still wait in order
    for (int i = 0; i < 4; i++) begin
      retire(1'b0, '0, 1'b1, recs[i]);
    end
    read_expect(REG_CHECK_CNT, "CHECK_CNT", 32'd20);
    read_expect(REG_MISMATCH_CNT, "MISMATCH_CNT", 32'd2);
  endtask

  task automatic clear_log();
    retire_t c;
    wb_write(REG_CTRL, 32'd1);
    expect_eq("err_irq_o", 32'(err_irq_o), 32'd0);
    read_expect(REG_STATUS, "STATUS", 32'd0);
    read_expect(REG_CTRL, "CTRL", 32'd0);
    read_expect(REG_CHECK_CNT, "CHECK_CNT", 32'd0);
    read_expect(REG_MISMATCH_CNT, "MISMATCH_CNT", 32'd0);
    read_expect(REG_FIRST_FIELDS, "FIRST_FIELDS", 32'd0);
    read_expect(REG_FIRST_PC, "FIRST_PC", 32'd0);
    c = random_retire();
    retire(1'b1, c, 1'b1, c);
    read_expect(REG_CHECK_CNT, "CHECK_CNT", 32'd1);
    read_expect(REG_MISMATCH_CNT, "MISMATCH_CNT", 32'd0);
  endtask

  initial begin
    void'($urandom(32'h6ac6_00d6));
    rst_i    = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    retire(1'b0, '0, 1'b0, '0);
    repeat (4) step();
    rst_i = 1'b0;

    aligned_match();
    skewed_match();
    masked_fields();
    first_mismatch_capture();
    stream_errors();
    clear_log();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: list.f
verilog/rvfi_pkg.sv
verilog/rvfi_cmp_regs_pkg.sv
verilog/rvfi_retire_fifo.sv
verilog/rvfi_field_compare.sv
verilog/rvfi_mismatch_log.sv
verilog/rvfi_cmp_wb_regs.sv
verilog/rvfi_checker_top.sv
tests/tb_rvfi_checker.sv

// File: Makefile
# Verilator flow for the lockstep retirement checker
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= tb_rvfi_checker
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
